//--- include/slot_sta_params.svh
/*
 * Slot status monitor parameters
 * Slot count, link word width, report FIFO depth and reader credits
 */
`ifndef SLOT_STA_PARAMS_SVH
`define SLOT_STA_PARAMS_SVH

// ==================================================
// Backplane geometry
// ==================================================

// Monitored slots
`define NUM_SLOTS 16

// Slot number width, from the slot count
`define SLOT_W ($clog2(`NUM_SLOTS))

// Link word width, flag + reserved + status
`define LINK_W 18

// ==================================================
// Report path
// ==================================================

// Report FIFO entries
`define QUEUE_DEPTH 4

// Credits granted by the reader after reset
`define CREDIT_MAX 2

`endif

//--- design/sta_link_pkg.sv
/*
 * Link word types for the slot status monitor
 * One 18-bit word read either as a frame header or as a status payload
 */
`include "slot_sta_params.svh"

package sta_link_pkg;

    // Header view, bit 17 set, slot number in the low bits
    typedef struct packed {
        logic                             flag;
        logic [`LINK_W-`SLOT_W-2:0]       rsvd;
        logic [`SLOT_W-1:0]               slot;
    } link_hdr_t;

    // Payload view, bit 16 unused
    typedef struct packed {
        logic        flag;
        logic        rsvd;
        logic [15:0] status;
    } link_pay_t;

    // Same word, two decodings
    typedef union packed {
        link_hdr_t hdr;
        link_pay_t pay;
    } link_word_u;

    // Position of a word in its frame, 0 means no open frame
    typedef logic [1:0] word_idx_t;

endpackage

//--- design/sta_report_pkg.sv
/*
 * Report record types
 * Kind of change and the record handed to the downstream reader
 */
`include "slot_sta_params.svh"

package sta_report_pkg;

    // Why a record was made
    typedef enum logic [0:0] {
        STATUS_CHANGE = 1'b0,
        HOT_PLUG      = 1'b1
    } rpt_kind_e;

    // ==================================================
    // Report record, 37 bits
    // ==================================================
    typedef struct packed {
        // Slot the frame came from
        logic [`SLOT_W-1:0] slot;
        // Event class
        rpt_kind_e          kind;
        // New first status word
        logic [15:0]        sta1;
        // New second status word
        logic [15:0]        sta2;
    } rpt_rec_t;

endpackage

//--- design/sta_ifaces.sv
/*
 * Internal buses of the slot status monitor
 * Decoded payload words and change events
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

// ==================================================
// Decoded word, decoder to capture
// ==================================================
interface sta_word_if;
    // One-cycle qualifier per payload word
    logic                    valid;
    // Slot from the frame header
    logic [`SLOT_W-1:0]      slot;
    // Word 1 or word 2
    sta_link_pkg::word_idx_t idx;
    // Status bits 15:0
    logic [15:0]             status;

    modport src (output valid, output slot, output idx, output status);
    modport dst (input valid, input slot, input idx, input status);
endinterface

// ==================================================
// Change event, capture to report queue
// ==================================================
interface sta_event_if;
    // Single-cycle push, no ready
    logic                     valid;
    sta_report_pkg::rpt_rec_t rec;

    modport src (output valid, output rec);
    modport dst (input valid, input rec);
endinterface

//--- design/sta_frame_decode.sv
/*
 * Status frame decoder
 * Tracks header slot and word position, forwards words 1 and 2
 * one cycle later tagged with slot and index
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module sta_frame_decode (
    input  logic                    clk_150m,
    input  logic                    rst_150m,
    input  logic                    link_valid,
    input  sta_link_pkg::link_word_u link_word,
    sta_word_if.src                 words
);

    // Slot latched from the last header
    logic [`SLOT_W-1:0]      slot_q;
    // Position of the next word in the frame
    sta_link_pkg::word_idx_t idx_q;
    logic                    is_hdr;
    logic                    is_pay;

    // Header view decides framing
    assign is_hdr = link_valid && link_word.hdr.flag;

    // Only words 1 and 2 carry status
    assign is_pay = link_valid && !link_word.pay.flag &&
                    (idx_q == 2'd1 || idx_q == 2'd2);

    // ==================================================
    // Frame tracking
    // ==================================================
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            slot_q <= '0;
            idx_q  <= 2'd0;
        end else if (!link_valid) begin
            // Frame ends with link_valid low
            idx_q <= 2'd0;
        end else if (is_hdr) begin
            // A header always opens a new frame
            slot_q <= link_word.hdr.slot;
            idx_q  <= 2'd1;
        end else if (idx_q != 2'd0 && idx_q != 2'd3) begin
            // Saturate at 3, later words are dropped
            idx_q <= idx_q + 2'd1;
        end
    end

    // Qualifier
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            words.valid <= 1'b0;
        end else begin
            words.valid <= is_pay;
        end
    end

    // Payload word, tagged with header slot
    always_ff @(posedge clk_150m) begin
        words.slot   <= slot_q;
        words.idx    <= idx_q;
        words.status <= link_word.pay.status;
    end

endmodule

//--- design/slot_sta_capture.sv
/*
 * Per-slot status capture
 * Stores both status words per slot, keeps hot-plug levels,
 * detects changes at word 2 and pushes one event per change
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module slot_sta_capture (
    input  logic                  clk_150m,
    input  logic                  rst_150m,
    input  logic                  hold,
    sta_word_if.dst               words,
    input  logic [`SLOT_W-1:0]    rd_slot,
    output logic [15:0]           rd_sta1,
    output logic [15:0]           rd_sta2,
    output logic [`NUM_SLOTS-1:0] hot_plug_req,
    sta_event_if.src              events
);

    // Stored status pair per slot
    logic [15:0] sta1_mem [`NUM_SLOTS];
    logic [15:0] sta2_mem [`NUM_SLOTS];
    logic        take1;
    logic        take2;
    // Word 1 staged for the word 2 comparison
    logic        stg_ok;
    logic [15:0] stg_new1;
    logic [15:0] stg_old1;
    logic        is_hot;
    logic        is_change;

    assign take1 = words.valid && (words.idx == 2'd1);
    assign take2 = words.valid && (words.idx == 2'd2);

    // Rising hot-plug flag wins over a plain change
    assign is_hot    = stg_new1[15] && !stg_old1[15];
    assign is_change = (stg_new1 != stg_old1) || (words.status != sta2_mem[words.slot]);

    // Combinational readback
    assign rd_sta1 = sta1_mem[rd_slot];
    assign rd_sta2 = sta2_mem[rd_slot];

    // ==================================================
    // Status store and hot-plug levels, frozen by hold
    // ==================================================
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                sta1_mem[i] <= '0;
                sta2_mem[i] <= '0;
            end
            hot_plug_req <= '0;
        end else if (!hold) begin
            if (take1) begin
                sta1_mem[words.slot]     <= words.status;
                hot_plug_req[words.slot] <= words.status[15];
            end
            if (take2) begin
                sta2_mem[words.slot] <= words.status;
            end
        end
    end

    // Stage valid, word 1 under hold arms nothing
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            stg_ok <= 1'b0;
        end else if (take1) begin
            stg_ok <= !hold;
        end else if (take2) begin
            stg_ok <= 1'b0;
        end
    end

    // Keep new and previous sta1, the store is already overwritten
    always_ff @(posedge clk_150m) begin
        if (take1) begin
            stg_new1 <= words.status;
            stg_old1 <= sta1_mem[words.slot];
        end
    end

    // ==================================================
    // Event push, cycle after word 2
    // ==================================================
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            events.valid <= 1'b0;
        end else begin
            events.valid <= take2 && !hold && stg_ok && (is_hot || is_change);
        end
    end

    always_ff @(posedge clk_150m) begin
        if (take2) begin
            events.rec.slot <= words.slot;
            events.rec.kind <= is_hot ? sta_report_pkg::HOT_PLUG : sta_report_pkg::STATUS_CHANGE;
            events.rec.sta1 <= stg_new1;
            events.rec.sta2 <= words.status;
        end
    end

endmodule

//--- design/sta_report_queue.sv
/*
 * Report queue with credit-based sending
 * Circular FIFO of records, sticky overflow on a push into a full queue,
 * head record sent while the reader has credit
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module sta_report_queue (
    input  logic                     clk_150m,
    input  logic                     rst_150m,
    sta_event_if.dst                 events,
    input  logic                     rpt_credit,
    output logic                     rpt_valid,
    output sta_report_pkg::rpt_rec_t rpt_rec,
    output logic                     overflow
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(`CREDIT_MAX + 1);

    sta_report_pkg::rpt_rec_t fifo_mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    // Entries held
    logic [CNT_W-1:0]         fill;
    // Records the reader can still take
    logic [CRD_W-1:0]         credit_cnt;
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign full  = (fill == CNT_W'(`QUEUE_DEPTH));
    assign empty = (fill == '0);
    // Push into a full queue is lost
    assign push  = events.valid && !full;
    // A credit returning this cycle can be spent at once
    assign pop   = !empty && ((credit_cnt != '0) || rpt_credit);

    assign rpt_valid = pop;
    assign rpt_rec   = fifo_mem[rd_ptr];

    // Record storage
    always_ff @(posedge clk_150m) begin
        if (push) begin
            fifo_mem[wr_ptr] <= events.rec;
        end
    end

    // ==================================================
    // Pointers, fill level, credits
    // ==================================================
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            credit_cnt <= CRD_W'(`CREDIT_MAX);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Returned credit and sent record cancel
            case ({rpt_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Sticky until reset
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            overflow <= 1'b0;
        end else if (events.valid && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

//--- design/slot_sta_top.sv
/*
 * Backplane slot status monitor, top level
 * Frame decode, per-slot capture and credit-controlled report queue
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module slot_sta_top (
    input  logic                      clk_150m,
    input  logic                      rst_150m,
    // Link word stream
    input  logic                      link_valid,
    input  logic [`LINK_W-1:0]        link_word,
    input  logic                      hold,
    // Readback by slot
    input  logic [`SLOT_W-1:0]        rd_slot,
    output logic [15:0]               rd_sta1,
    output logic [15:0]               rd_sta2,
    output logic [`NUM_SLOTS-1:0]     hot_plug_req,
    // Report stream to the reader
    output logic                      rpt_valid,
    output logic [`SLOT_W-1:0]        rpt_slot,
    output sta_report_pkg::rpt_kind_e rpt_kind,
    output logic [15:0]               rpt_sta1,
    output logic [15:0]               rpt_sta2,
    input  logic                      rpt_credit,
    output logic                      overflow
);

    sta_report_pkg::rpt_rec_t rpt_rec;

    // ==================================================
    // Internal buses
    // ==================================================
    sta_word_if  word_bus ();
    sta_event_if event_bus ();

    sta_frame_decode u_decode (
        .clk_150m   (clk_150m),
        .rst_150m   (rst_150m),
        .link_valid (link_valid),
        .link_word  (link_word),
        .words      (word_bus.src)
    );

    slot_sta_capture u_capture (
        .clk_150m     (clk_150m),
        .rst_150m     (rst_150m),
        .hold         (hold),
        .words        (word_bus.dst),
        .rd_slot      (rd_slot),
        .rd_sta1      (rd_sta1),
        .rd_sta2      (rd_sta2),
        .hot_plug_req (hot_plug_req),
        .events       (event_bus.src)
    );

    sta_report_queue u_queue (
        .clk_150m   (clk_150m),
        .rst_150m   (rst_150m),
        .events     (event_bus.dst),
        .rpt_credit (rpt_credit),
        .rpt_valid  (rpt_valid),
        .rpt_rec    (rpt_rec),
        .overflow   (overflow)
    );

    // Record fields onto plain ports
    assign rpt_slot = rpt_rec.slot;
    assign rpt_kind = rpt_rec.kind;
    assign rpt_sta1 = rpt_rec.sta1;
    assign rpt_sta2 = rpt_rec.sta2;

endmodule

//--- test/slot_sta_properties.sv
/*
 * Protocol assertions for the slot status monitor
 * Credit range and credit gating in the report queue, sticky overflow,
 * stored status and hot-plug levels frozen while hold is high
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module slot_sta_properties (
    input logic                             clk_150m,
    input logic                             rst_150m,
    input logic [$clog2(`CREDIT_MAX+1)-1:0] credit_cnt,
    input logic                             rpt_valid,
    input logic                             rpt_credit,
    input logic                             overflow,
    input logic                             hold,
    input logic [15:0]                      sta1_mem [`NUM_SLOTS],
    input logic [15:0]                      sta2_mem [`NUM_SLOTS],
    input logic [`NUM_SLOTS-1:0]            hot_plug_req
);

    // Both status arrays side by side
    logic [32*`NUM_SLOTS-1:0] sta_flat;
    // Credits as the reader counts them at the top level ports
    int                       reader_credit;
    // Failures per assertion
    int unsigned range_fails = 0;
    int unsigned gate_fails = 0;
    int unsigned sticky_fails = 0;
    int unsigned hold_fails = 0;
    // Total failures read by the testbench
    int unsigned prop_fails;

    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            sta_flat[32*i +: 32] = {sta1_mem[i], sta2_mem[i]};
        end
    end

    // One credit per returned pulse, one spent per record
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            reader_credit <= `CREDIT_MAX;
        end else begin
            reader_credit <= reader_credit + int'(rpt_credit) - int'(rpt_valid);
        end
    end

    assign prop_fails = range_fails + gate_fails + sticky_fails + hold_fails;

    // ==================================================
    // Report queue
    // ==================================================
    a_credit_range: assert property (@(posedge clk_150m) disable iff (!rst_150m)
        credit_cnt <= `CREDIT_MAX)
        else begin
            $error("credit counter %0d above its limit", credit_cnt);
            range_fails++;
        end

    // A credit returning in the same cycle may be spent at once
    a_credit_gate: assert property (@(posedge clk_150m) disable iff (!rst_150m)
        rpt_valid |-> (reader_credit > 0 || rpt_credit))
        else begin
            $error("record sent with no credit");
            gate_fails++;
        end

    a_ovf_sticky: assert property (@(posedge clk_150m) disable iff (!rst_150m)
        overflow |=> overflow)
        else begin
            $error("overflow fell without reset");
            sticky_fails++;
        end

    // ==================================================
    // Capture
    // ==================================================
    a_hold_freeze: assert property (@(posedge clk_150m) disable iff (!rst_150m)
        hold |=> ($stable(sta_flat) && $stable(hot_plug_req)))
        else begin
            $error("stored status or hot-plug level moved under hold");
            hold_fails++;
        end

endmodule

// Watches the queue credits and the capture store from the top level
bind slot_sta_top slot_sta_properties u_props (
    .clk_150m     (clk_150m),
    .rst_150m     (rst_150m),
    .credit_cnt   (u_queue.credit_cnt),
    .rpt_valid    (rpt_valid),
    .rpt_credit   (rpt_credit),
    .overflow     (overflow),
    .hold         (hold),
    .sta1_mem     (u_capture.sta1_mem),
    .sta2_mem     (u_capture.sta2_mem),
    .hot_plug_req (hot_plug_req)
);

//--- test/slot_sta_tb.sv
/*
 * Testbench for the slot status monitor
 * Random status frames against a per-slot reference model,
 * record and readback checks, hold, hot plug and credit sequences
 */
`timescale 1ns/10ps
`include "slot_sta_params.svh"

module slot_sta_tb;

    localparam int SW         = `SLOT_W;
    // Header, two words, gap, settle and readback
    localparam int FRAME_CYC  = 10;
    localparam int NUM_FRAMES = 17;
    localparam int SEQ_CYC    = 3 + NUM_FRAMES * FRAME_CYC + 4 * `QUEUE_DEPTH + 10;
    localparam int TIMEOUT    = 4 * SEQ_CYC;

    logic                      clk_150m;
    logic                      rst_150m;
    logic                      link_valid;
    logic [`LINK_W-1:0]        link_word;
    logic                      hold;
    logic [SW-1:0]             rd_slot;
    logic [15:0]               rd_sta1;
    logic [15:0]               rd_sta2;
    logic [`NUM_SLOTS-1:0]     hot_plug_req;
    logic                      rpt_valid;
    logic [SW-1:0]             rpt_slot;
    sta_report_pkg::rpt_kind_e rpt_kind;
    logic [15:0]               rpt_sta1;
    logic [15:0]               rpt_sta2;
    logic                      rpt_credit;
    logic                      overflow;

    // ==================================================
    // Reference model
    // ==================================================
    logic [15:0]               mdl_sta1 [`NUM_SLOTS];
    logic [15:0]               mdl_sta2 [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0]     mdl_hp;
    logic                      mdl_ovf;
    // Records pushed and not yet seen on rpt_valid
    sta_report_pkg::rpt_rec_t  exp_q [$];
    bit                        auto_credit;
    int unsigned               sent_cnt = 0;
    int unsigned               returned_cnt = 0;
    int unsigned               cycle_cnt = 0;
    int unsigned               rec_errs = 0;
    int unsigned               st_errs = 0;

    slot_sta_top DUT (.*);

    always #10 clk_150m = ~clk_150m;

    function automatic bit value_matches(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp)
        else $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        return got === exp;
    endfunction

    task automatic report_counts();
        $display("Error counts: record %0d, state %0d, property %0d",
                 rec_errs, st_errs, DUT.u_props.prop_fails);
    endtask

    task automatic expect_record(sta_report_pkg::rpt_rec_t e);
        rec_errs += 32'(!value_matches("rpt_slot", 16'(rpt_slot), 16'(e.slot)));
        rec_errs += 32'(!value_matches("rpt_kind", 16'(rpt_kind), 16'(e.kind)));
        rec_errs += 32'(!value_matches("rpt_sta1", rpt_sta1, e.sta1));
        rec_errs += 32'(!value_matches("rpt_sta2", rpt_sta2, e.sta2));
    endtask

    // Record sent and credit returned are counted at the rising edge
    always @(posedge clk_150m) begin
        if (rst_150m && rpt_valid) begin
            sent_cnt++;
            if (exp_q.size() == 0) begin
                $display("Record from slot %0d arrived when none was expected", rpt_slot);
                rec_errs++;
            end else begin
                expect_record(exp_q.pop_front());
            end
        end
        if (rst_150m && rpt_credit) begin
            returned_cnt++;
        end
    end

    always @(posedge clk_150m) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout, run did not finish within %0d cycles", TIMEOUT);
            report_counts();
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Falling edge, reader hands back one credit per owed record
    task automatic next_cycle();
        @(negedge clk_150m);
        rpt_credit = auto_credit && (sent_cnt > returned_cnt);
    endtask

    task automatic check_state(logic [SW-1:0] slot);
        rd_slot = slot;
        next_cycle();
        st_errs += 32'(!value_matches("rd_sta1", rd_sta1, mdl_sta1[slot]));
        st_errs += 32'(!value_matches("rd_sta2", rd_sta2, mdl_sta2[slot]));
        st_errs += 32'(!value_matches("hot_plug_req", hot_plug_req, mdl_hp));
        st_errs += 32'(!value_matches("overflow", 16'(overflow), 16'(mdl_ovf)));
    endtask

    task automatic send_frame(logic [SW-1:0] slot, logic [15:0] w1, logic [15:0] w2, bit full);
        sta_report_pkg::rpt_rec_t rec;
        logic [15:0]              old1;
        logic [15:0]              old2;
        old1 = mdl_sta1[slot];
        old2 = mdl_sta2[slot];
        // Nothing moves under hold
        if (!hold) begin
            mdl_sta1[slot] = w1;
            mdl_hp[slot]   = w1[15];
            if (full) begin
                mdl_sta2[slot] = w2;
                rec.slot = slot;
                rec.sta1 = w1;
                rec.sta2 = w2;
                if (w1[15] && !old1[15]) begin
                    rec.kind = sta_report_pkg::HOT_PLUG;
                end else begin
                    rec.kind = sta_report_pkg::STATUS_CHANGE;
                end
                // Full queue drops the event
                if (rec.kind == sta_report_pkg::HOT_PLUG || w1 != old1 || w2 != old2) begin
                    if (exp_q.size() == `QUEUE_DEPTH) begin
                        mdl_ovf = 1'b1;
                    end else begin
                        exp_q.push_back(rec);
                    end
                end
            end
        end
        next_cycle();
        link_valid = 1'b1;
        link_word  = {1'b1, {(`LINK_W-SW-1){1'b0}}, slot};
        next_cycle();
        link_word = {2'b00, w1};
        if (full) begin
            next_cycle();
            link_word = {2'b00, w2};
        end
        next_cycle();
        link_valid = 1'b0;
        link_word  = '0;
        // Push two cycles after word 2, record one later
        repeat (4) next_cycle();
        check_state(slot);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || sent_cnt != returned_cnt) begin
            next_cycle();
        end
    endtask

    initial begin
        logic [SW-1:0] s;
        int unsigned   sent_before;
        void'($urandom(32'hdcaedc3a));
        clk_150m    = 1'b0;
        rst_150m    = 1'b0;
        link_valid  = 1'b0;
        link_word   = '0;
        hold        = 1'b0;
        rd_slot     = '0;
        rpt_credit  = 1'b0;
        auto_credit = 1'b1;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            mdl_sta1[i] = '0;
            mdl_sta2[i] = '0;
        end
        mdl_hp  = '0;
        mdl_ovf = 1'b0;
        repeat (3) @(negedge clk_150m);
        rst_150m = 1'b1;
        next_cycle();

        // Readback, full frame then one cut after word 1
        s = SW'($urandom);
        send_frame(s, 16'($urandom), 16'($urandom), 1'b1);
        send_frame(s, 16'($urandom), 16'($urandom), 1'b0);

        // Hold freezes store and levels, no records
        hold = 1'b1;
        send_frame(s, ~mdl_sta1[s], 16'($urandom), 1'b1);
        send_frame(SW'(s + 1), 16'($urandom) | 16'h8000, 16'($urandom), 1'b1);
        hold = 1'b0;

        // Hot plug rises then falls
        s = SW'(s + 2);
        send_frame(s, 16'($urandom) & 16'h7fff, 16'($urandom), 1'b1);
        send_frame(s, 16'($urandom) | 16'h8000, 16'($urandom), 1'b1);
        send_frame(s, mdl_sta1[s] & 16'h7fff, mdl_sta2[s], 1'b1);

        // Change detection, repeat then word 2 only
        s = SW'(s + 1);
        send_frame(s, 16'($urandom), 16'($urandom), 1'b1);
        send_frame(s, mdl_sta1[s], mdl_sta2[s], 1'b1);
        send_frame(s, mdl_sta1[s], ~mdl_sta2[s], 1'b1);

        // ==================================================
        // Credits, fill, overflow, drain
        // ==================================================
        wait_drained();
        auto_credit = 1'b0;
        sent_before = sent_cnt;
        repeat (`CREDIT_MAX + `QUEUE_DEPTH + 1) begin
            s = SW'($urandom);
            send_frame(s, 16'($urandom), ~mdl_sta2[s], 1'b1);
        end
        st_errs += 32'(!value_matches("rpt_valid count", 16'(sent_cnt - sent_before),
                                      16'(`CREDIT_MAX)));
        auto_credit = 1'b1;
        wait_drained();
        check_state(s);

        report_counts();
        if (rec_errs + st_errs + DUT.u_props.prop_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
design/sta_link_pkg.sv
design/sta_report_pkg.sv
design/sta_ifaces.sv
design/sta_frame_decode.sv
design/slot_sta_capture.sv
design/sta_report_queue.sv
design/slot_sta_top.sv
test/slot_sta_properties.sv
test/slot_sta_tb.sv

//--- Makefile
# Verilator build for the slot status monitor

VERILATOR  ?= verilator
TOP        := slot_sta_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the pass line shows up in the run output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
